// File: source/dcache_defs.svh
// cache geometry and field widths as macros; include wherever a width or size is needed
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

`define DCACHE_WAYS 4          // associativity
`define DCACHE_SETS 256        // sets per way, one word each
`define DCACHE_WAY_W 2         // bits to name a way
`define DCACHE_AGE_W 2         // lru age bits per way

`define DCACHE_ADDR_W 20       // byte address, 1 MB space
`define DCACHE_INDEX_W 8       // set select
`define DCACHE_TAG_W 10        // upper address bits kept per line
`define DCACHE_OFFSET_W 2      // byte within word

`define DCACHE_WORD_W 32       // line = one word
`define DCACHE_BYTES 4         // byte lanes per word

// way i starts with age i, packed way 3 down to way 0
`define DCACHE_RESET_AGES 8'b11_10_01_00

`endif

// File: source/dcache_addr_pkg.sv
// request address types, field extraction and store size encoding for the data cache
`include "dcache_defs.svh"

package dcache_addr_pkg;

    typedef logic [`DCACHE_ADDR_W-1:0]   dc_addr_t;    // byte address of a request
    typedef logic [`DCACHE_INDEX_W-1:0]  dc_index_t;   // set number
    typedef logic [`DCACHE_TAG_W-1:0]    dc_tag_t;     // compared against stored tag
    typedef logic [`DCACHE_OFFSET_W-1:0] dc_offset_t;  // byte lane of the access

    // store width, encoding kept from the cpu side
    typedef enum logic [1:0] {
        DC_SIZE_BYTE    = 2'b00,
        DC_SIZE_HALF    = 2'b01,
        DC_SIZE_WORD    = 2'b10,
        DC_SIZE_ILLEGAL = 2'b11   // writes nothing
    } dc_size_e;

    function automatic dc_offset_t dc_offset_of(dc_addr_t a);
        return a[`DCACHE_OFFSET_W-1:0];                          // bits 1:0
    endfunction

    function automatic dc_index_t dc_index_of(dc_addr_t a);
        return a[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];          // bits 9:2
    endfunction

    function automatic dc_tag_t dc_tag_of(dc_addr_t a);
        return a[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];            // bits 19:10
    endfunction

endpackage

// File: source/dcache_line_pkg.sv
// types for what a cache line holds: way number, lru age, data word and per-way flags
`include "dcache_defs.svh"

package dcache_line_pkg;

    typedef logic [`DCACHE_WAY_W-1:0]  dc_way_t;      // way 0..3
    typedef logic [`DCACHE_AGE_W-1:0]  dc_age_t;      // 0 newest, 3 oldest
    typedef logic [`DCACHE_WORD_W-1:0] dc_word_t;     // payload of one line
    typedef logic [`DCACHE_BYTES-1:0]  dc_be_t;       // byte lane enables
    typedef logic [`DCACHE_WAYS-1:0]   dc_way_vec_t;  // one flag per way

endpackage

// File: source/dcache_way_ram.sv
// synchronous single-way RAM with byte-masked write and same-edge write-to-read forwarding
`include "dcache_defs.svh"

module dcache_way_ram #(
    parameter int WIDTH_BYTES = 4   // 4 for data ways, 2 for tag RAMs
) (
    input  logic                       CLK,
    input  dcache_addr_pkg::dc_index_t rd_addr,   // set looked up this edge
    input  logic                       wr_en,
    input  dcache_addr_pkg::dc_index_t wr_addr,
    input  logic [WIDTH_BYTES-1:0]     wr_be,
    input  logic [WIDTH_BYTES*8-1:0]   wr_data,
    output logic [WIDTH_BYTES*8-1:0]   rd_data    // registered read
);

    logic [WIDTH_BYTES*8-1:0] mem [`DCACHE_SETS];
    logic                     same_set;             // write and read hit one entry

    assign same_set = wr_en && (wr_addr == rd_addr);

    always_ff @(posedge CLK) begin
        for (int b = 0; b < WIDTH_BYTES; b++) begin
            if (wr_en && wr_be[b]) begin
                mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
            end
            // lanes being written this edge come from the write, others from the array
            if (same_set && wr_be[b]) begin
                rd_data[b*8 +: 8] <= wr_data[b*8 +: 8];
            end else begin
                rd_data[b*8 +: 8] <= mem[rd_addr][b*8 +: 8];
            end
        end
    end

    // lookup only strobes a way when it has a lane to write
    a_be_nonzero: assert property (@(posedge CLK) wr_en |-> (wr_be != '0))
        else $error("way RAM write with no byte enabled");

endmodule

// File: source/dcache_tag_store.sv
// tag RAMs plus resettable valid, dirty and lru flop arrays, read per set with forwarding
`include "dcache_defs.svh"

module dcache_tag_store (
    input  logic                                         CLK,
    input  logic                                         arst_n,
    input  dcache_addr_pkg::dc_index_t                   rd_index,    // set of new request
    input  logic                                         upd_en,      // write back set state
    input  dcache_addr_pkg::dc_index_t                   upd_index,
    input  dcache_line_pkg::dc_way_vec_t                 upd_tag_en,  // ways taking new tag
    input  dcache_addr_pkg::dc_tag_t                     upd_tag,
    input  dcache_line_pkg::dc_way_vec_t                 upd_valid,
    input  dcache_line_pkg::dc_way_vec_t                 upd_dirty,
    input  dcache_line_pkg::dc_age_t [`DCACHE_WAYS-1:0]  upd_age,
    output dcache_addr_pkg::dc_tag_t [`DCACHE_WAYS-1:0]  tags,
    output dcache_line_pkg::dc_way_vec_t                 valid,
    output dcache_line_pkg::dc_way_vec_t                 dirty,
    output dcache_line_pkg::dc_age_t [`DCACHE_WAYS-1:0]  ages
);
    import dcache_line_pkg::*;

    localparam int TAG_RAM_BYTES = 2;                  // tag padded to 16 bits
    localparam int TAG_RAM_W     = TAG_RAM_BYTES * 8;

    dc_way_vec_t                valid_mem [`DCACHE_SETS];
    dc_way_vec_t                dirty_mem [`DCACHE_SETS];
    dc_age_t [`DCACHE_WAYS-1:0] age_mem   [`DCACHE_SETS];
    logic                       fwd;                   // update lands on the set being read
    logic [`DCACHE_WAYS-1:0]    age_seen;              // one bit per age value present

    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_tag
        logic [TAG_RAM_W-1:0] tag_raw;

        dcache_way_ram #(
            .WIDTH_BYTES (TAG_RAM_BYTES)
        ) u_tag_ram (
            .CLK     (CLK),
            .rd_addr (rd_index),
            .wr_en   (upd_en && upd_tag_en[w]),      // only a fill rewrites a tag
            .wr_addr (upd_index),
            .wr_be   ({TAG_RAM_BYTES{1'b1}}),
            .wr_data (TAG_RAM_W'(upd_tag)),
            .rd_data (tag_raw)
        );

        assign tags[w] = tag_raw[`DCACHE_TAG_W-1:0];   // upper pad bits dropped
    end

    assign fwd = upd_en && (upd_index == rd_index);

    // set state arrays, cleared so the cache comes up empty
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
                age_mem[s]   <= `DCACHE_RESET_AGES;
            end
        end else if (upd_en) begin
            valid_mem[upd_index] <= upd_valid;
            dirty_mem[upd_index] <= upd_dirty;
            age_mem[upd_index]   <= upd_age;
        end
    end

    // registered read, same timing as the tag RAMs
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
            dirty <= '0;
            ages  <= `DCACHE_RESET_AGES;
        end else if (fwd) begin
            valid <= upd_valid;                        // take state from in-flight update
            dirty <= upd_dirty;
            ages  <= upd_age;
        end else begin
            valid <= valid_mem[rd_index];
            dirty <= dirty_mem[rd_index];
            ages  <= age_mem[rd_index];
        end
    end

    always_comb begin
        age_seen = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            age_seen[ages[w]] = 1'b1;
        end
    end

    // lookup age update must keep each set a permutation of 0..3
    a_ages_distinct: assert property (@(posedge CLK) disable iff (!arst_n) &age_seen)
        else $error("lru ages of a set are not distinct");

endmodule

// File: source/dcache_lookup.sv
// request stage, tag compare, hit or victim way choice, lru and store-mask update, response
`include "dcache_defs.svh"

module dcache_lookup (
    input  logic                                         CLK,
    input  logic                                         arst_n,
    input  logic                                         read_en,
    input  logic                                         write_en,
    input  logic                                         fill,
    input  dcache_addr_pkg::dc_addr_t                    addr,
    input  dcache_addr_pkg::dc_size_e                    store_size,
    input  dcache_line_pkg::dc_word_t                    wdata,       // lane-aligned store data
    input  dcache_addr_pkg::dc_tag_t [`DCACHE_WAYS-1:0]  tags,
    input  dcache_line_pkg::dc_way_vec_t                 valid,
    input  dcache_line_pkg::dc_way_vec_t                 dirty,
    input  dcache_line_pkg::dc_age_t [`DCACHE_WAYS-1:0]  ages,
    input  dcache_line_pkg::dc_word_t [`DCACHE_WAYS-1:0] way_data,
    output logic                                         upd_en,
    output dcache_addr_pkg::dc_index_t                   upd_index,
    output dcache_line_pkg::dc_way_vec_t                 upd_tag_en,
    output dcache_addr_pkg::dc_tag_t                     upd_tag,
    output dcache_line_pkg::dc_way_vec_t                 upd_valid,
    output dcache_line_pkg::dc_way_vec_t                 upd_dirty,
    output dcache_line_pkg::dc_age_t [`DCACHE_WAYS-1:0]  upd_age,
    output dcache_line_pkg::dc_way_vec_t                 data_we,
    output dcache_line_pkg::dc_be_t                      data_be,
    output dcache_line_pkg::dc_word_t                    data_wdata,
    output logic                                         resp_valid,
    output logic                                         hit,
    output logic                                         miss,
    output dcache_line_pkg::dc_word_t                    rdata,
    output logic                                         evict_valid,
    output dcache_addr_pkg::dc_tag_t                     evict_tag,
    output dcache_line_pkg::dc_word_t                    evict_data,
    output logic                                         evict_dirty
);
    import dcache_addr_pkg::*;
    import dcache_line_pkg::*;

    // valid, hit, miss, rdata, evict valid, tag, data, dirty
    localparam int RESP_W = 3 + `DCACHE_WORD_W + 1 + `DCACHE_TAG_W + `DCACHE_WORD_W + 1;
    localparam dc_age_t AGE_OLDEST = dc_age_t'(`DCACHE_WAYS - 1);

    logic              rd_q, wr_q, fill_q;   // registered op strobes
    dc_addr_t          addr_q;
    dc_size_e          size_q;
    dc_word_t          wdata_q;
    dc_tag_t           req_tag;
    dc_offset_t        req_off;
    logic              lookup;               // read or store in stage 2
    logic              hit_any;
    logic              store_hit;            // hit store with at least one lane
    logic              evict_live;           // fill victim holds a valid line
    dc_way_vec_t       match;
    dc_way_vec_t       sel_onehot;
    dc_way_t           hit_way, victim, sel_way;
    dc_be_t            store_be;
    logic [RESP_W-1:0] resp_c, resp_s, resp_q;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            rd_q   <= 1'b0;
            wr_q   <= 1'b0;
            fill_q <= 1'b0;
        end else begin
            rd_q   <= read_en;
            wr_q   <= write_en;
            fill_q <= fill;
        end
    end

    always_ff @(posedge CLK) begin
        addr_q  <= addr;
        size_q  <= store_size;
        wdata_q <= wdata;
    end

    assign req_tag = dc_tag_of(addr_q);
    assign req_off = dc_offset_of(addr_q);
    assign lookup  = rd_q || wr_q;

    always_comb begin
        match   = '0;
        hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            match[w] = valid[w] && (tags[w] == req_tag);
            if (match[w]) begin
                hit_way = dc_way_t'(w);
            end
        end
    end

    assign hit_any = lookup && (|match);

    // lowest invalid way wins, otherwise the oldest
    always_comb begin
        victim = '0;
        for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
            if (ages[w] == AGE_OLDEST) begin
                victim = dc_way_t'(w);
            end
        end
        for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
            if (!valid[w]) begin
                victim = dc_way_t'(w);
            end
        end
    end

    always_comb begin
        case (size_q)
            DC_SIZE_BYTE: store_be = dc_be_t'(1) << req_off;
            DC_SIZE_HALF: store_be = (req_off == 2'd0) ? 4'b0011 :
                                     (req_off == 2'd2) ? 4'b1100 : 4'b0000;
            DC_SIZE_WORD: store_be = (req_off == 2'd0) ? 4'b1111 : 4'b0000;
            default:      store_be = 4'b0000;   // illegal size, no lanes
        endcase
    end

    assign sel_way    = fill_q ? victim : hit_way;
    assign sel_onehot = dc_way_vec_t'(1) << sel_way;
    assign store_hit  = wr_q && hit_any && (store_be != '0);
    assign evict_live = fill_q && valid[victim];

    // touched way becomes newest, ways younger than it age by one
    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (dc_way_t'(w) == sel_way) begin
                upd_age[w] = '0;
            end else if (ages[w] < ages[sel_way]) begin
                upd_age[w] = ages[w] + 1'b1;
            end else begin
                upd_age[w] = ages[w];
            end
        end
    end

    assign upd_en     = fill_q || hit_any;            // misses leave the set alone
    assign upd_index  = dc_index_of(addr_q);
    assign upd_tag_en = fill_q ? sel_onehot : '0;
    assign upd_tag    = req_tag;
    assign upd_valid  = fill_q ? (valid | sel_onehot) : valid;
    assign upd_dirty  = fill_q    ? (dirty & ~sel_onehot) :
                        store_hit ? (dirty | sel_onehot) : dirty;
    assign data_we    = (fill_q || store_hit) ? sel_onehot : '0;
    assign data_be    = fill_q ? '1 : store_be;        // fill writes whole word
    assign data_wdata = wdata_q;

    assign resp_c = {
        lookup || fill_q,
        hit_any,
        lookup && !hit_any,
        (rd_q && hit_any) ? way_data[hit_way] : dc_word_t'(0),
        evict_live,
        evict_live ? tags[victim] : dc_tag_t'(0),
        evict_live ? way_data[victim] : dc_word_t'(0),
        evict_live && dirty[victim]
    };

    // one extra stage puts the response after the second edge
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            resp_s <= '0;
            resp_q <= '0;
        end else begin
            resp_s <= resp_c;
            resp_q <= resp_s;
        end
    end

    assign {resp_valid, hit, miss, rdata, evict_valid, evict_tag, evict_data, evict_dirty} =
        resp_q;

    a_one_strobe: assert property (@(posedge CLK) disable iff (!arst_n)
        $onehot0({read_en, write_en, fill}))
        else $error("more than one request strobe high");

    // a tag is installed only into a way picked as victim, never twice per set
    a_one_match: assert property (@(posedge CLK) disable iff (!arst_n)
        lookup |-> $onehot0(match))
        else $error("tag matches in more than one way");

endmodule

// File: source/dcache_top.sv
// data cache top, ties the tag store, four data ways and the lookup pipeline together
`include "dcache_defs.svh"

module dcache_top (
    input  logic                         CLK,
    input  logic                         arst_n,
    input  logic                         read_en,
    input  logic                         write_en,
    input  logic                         fill,
    input  dcache_addr_pkg::dc_addr_t    addr,
    input  dcache_addr_pkg::dc_size_e    store_size,
    input  dcache_line_pkg::dc_word_t    wdata,
    output logic                         resp_valid,
    output logic                         hit,
    output logic                         miss,
    output dcache_line_pkg::dc_word_t    rdata,
    output logic                         evict_valid,
    output dcache_addr_pkg::dc_tag_t     evict_tag,
    output dcache_line_pkg::dc_word_t    evict_data,
    output logic                         evict_dirty
);
    import dcache_addr_pkg::*;
    import dcache_line_pkg::*;

    dc_index_t                   rd_index;     // set of incoming request
    dc_tag_t [`DCACHE_WAYS-1:0]  tags;
    dc_way_vec_t                 valid, dirty;
    dc_age_t [`DCACHE_WAYS-1:0]  ages, upd_age;
    dc_word_t [`DCACHE_WAYS-1:0] way_data;
    logic                        upd_en;
    dc_index_t                   upd_index;    // set of request in stage 2
    dc_way_vec_t                 upd_tag_en, upd_valid, upd_dirty, data_we;
    dc_tag_t                     upd_tag;
    dc_be_t                      data_be;
    dc_word_t                    data_wdata;

    assign rd_index = dc_index_of(addr);

    dcache_tag_store u_tag_store (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .rd_index   (rd_index),
        .upd_en     (upd_en),
        .upd_index  (upd_index),
        .upd_tag_en (upd_tag_en),
        .upd_tag    (upd_tag),
        .upd_valid  (upd_valid),
        .upd_dirty  (upd_dirty),
        .upd_age    (upd_age),
        .tags       (tags),
        .valid      (valid),
        .dirty      (dirty),
        .ages       (ages)
    );

    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        dcache_way_ram #(
            .WIDTH_BYTES (`DCACHE_BYTES)
        ) u_data_ram (
            .CLK     (CLK),
            .rd_addr (rd_index),
            .wr_en   (data_we[w]),
            .wr_addr (upd_index),
            .wr_be   (data_be),
            .wr_data (data_wdata),
            .rd_data (way_data[w])
        );
    end

    dcache_lookup u_lookup (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .read_en     (read_en),
        .write_en    (write_en),
        .fill        (fill),
        .addr        (addr),
        .store_size  (store_size),
        .wdata       (wdata),
        .tags        (tags),
        .valid       (valid),
        .dirty       (dirty),
        .ages        (ages),
        .way_data    (way_data),
        .upd_en      (upd_en),
        .upd_index   (upd_index),
        .upd_tag_en  (upd_tag_en),
        .upd_tag     (upd_tag),
        .upd_valid   (upd_valid),
        .upd_dirty   (upd_dirty),
        .upd_age     (upd_age),
        .data_we     (data_we),
        .data_be     (data_be),
        .data_wdata  (data_wdata),
        .resp_valid  (resp_valid),
        .hit         (hit),
        .miss        (miss),
        .rdata       (rdata),
        .evict_valid (evict_valid),
        .evict_tag   (evict_tag),
        .evict_data  (evict_data),
        .evict_dirty (evict_dirty)
    );

endmodule

// File: tb/dcache_tb_vectors.svh
// request table for the data cache testbench, included in the testbench module body
// read_row: name, addr, hit, rdata | store_row: name, addr, size, data, hit
// fill_row: name, addr, data, evict valid, evict tag, evict data, evict dirty
    task automatic load_vectors();
        // cache comes up empty
        read_row("rd_empty_a", addr_of(10'h3ff, 8'h00, 2'd0), 1'b0, 32'h0);
        read_row("rd_empty_b", addr_of(10'h155, 8'h7f, 2'd0), 1'b0, 32'h0);
        fill_row("fill_empty", addr_of(10'h011, 8'h10, 2'd0), 32'hcafe0001, 0, 10'h0, 32'h0, 0);
        // fill then read, first read right behind the fill
        read_row("rd_after_fill", addr_of(10'h011, 8'h10, 2'd0), 1'b1, 32'hcafe0001);
        fill_row("fill_idx20", addr_of(10'h020, 8'h20, 2'd0), 32'h12345678, 0, 10'h0, 32'h0, 0);
        read_row("rd_idx20", addr_of(10'h020, 8'h20, 2'd0), 1'b1, 32'h12345678);
        // partial stores merge lane by lane
        store_row("st_byte_off0", addr_of(10'h020, 8'h20, 2'd0), DC_SIZE_BYTE, 32'h000000aa, 1);
        store_row("st_byte_off1", addr_of(10'h020, 8'h20, 2'd1), DC_SIZE_BYTE, 32'h0000bb00, 1);
        store_row("st_byte_off2", addr_of(10'h020, 8'h20, 2'd2), DC_SIZE_BYTE, 32'h00cc0000, 1);
        store_row("st_byte_off3", addr_of(10'h020, 8'h20, 2'd3), DC_SIZE_BYTE, 32'hdd000000, 1);
        read_row("rd_bytes_merged", addr_of(10'h020, 8'h20, 2'd0), 1'b1, 32'hddccbbaa);
        store_row("st_half_off0", addr_of(10'h020, 8'h20, 2'd0), DC_SIZE_HALF, 32'h00001111, 1);
        store_row("st_half_off2", addr_of(10'h020, 8'h20, 2'd2), DC_SIZE_HALF, 32'h22220000, 1);
        store_row("st_half_odd", addr_of(10'h020, 8'h20, 2'd1), DC_SIZE_HALF, 32'heeeeeeee, 1);
        store_row("st_illegal", addr_of(10'h020, 8'h20, 2'd0), DC_SIZE_ILLEGAL, 32'hffffffff, 1);
        read_row("rd_halves_merged", addr_of(10'h020, 8'h20, 2'd0), 1'b1, 32'h22221111);
        store_row("st_word", addr_of(10'h020, 8'h20, 2'd0), DC_SIZE_WORD, 32'h0badf00d, 1);
        read_row("rd_word", addr_of(10'h020, 8'h20, 2'd0), 1'b1, 32'h0badf00d);
        store_row("st_absent", addr_of(10'h021, 8'h20, 2'd0), DC_SIZE_WORD, 32'h13579bdf, 0);
        // lru order in set 0x40, ages noted as way0..way3 after each row
        fill_row("fill_w0", addr_of(10'h101, 8'h40, 2'd0), 32'ha0000001, 0, 10'h0, 32'h0, 0);
        fill_row("fill_w1", addr_of(10'h102, 8'h40, 2'd0), 32'ha0000002, 0, 10'h0, 32'h0, 0);
        fill_row("fill_w2", addr_of(10'h103, 8'h40, 2'd0), 32'ha0000003, 0, 10'h0, 32'h0, 0);
        fill_row("fill_w3", addr_of(10'h104, 8'h40, 2'd0), 32'ha0000004, 0, 10'h0, 32'h0, 0);
        read_row("rd_w0", addr_of(10'h101, 8'h40, 2'd0), 1'b1, 32'ha0000001);   // 0 3 2 1
        store_row("st_w2", addr_of(10'h103, 8'h40, 2'd0), DC_SIZE_BYTE, 32'h000000ee, 1);
        read_row("rd_w3", addr_of(10'h104, 8'h40, 2'd0), 1'b1, 32'ha0000004);   // 2 3 1 0
        fill_row("fill_ev_clean", addr_of(10'h105, 8'h40, 2'd0), 32'ha0000005,
                 1, 10'h102, 32'ha0000002, 0);                                    // 3 0 2 1
        read_row("rd_w0_again", addr_of(10'h101, 8'h40, 2'd0), 1'b1, 32'ha0000001);
        fill_row("fill_ev_dirty", addr_of(10'h106, 8'h40, 2'd0), 32'ha0000006,
                 1, 10'h103, 32'ha00000ee, 1);                                    // 1 2 0 3
        read_row("rd_evicted", addr_of(10'h103, 8'h40, 2'd0), 1'b0, 32'h0);
        read_row("rd_w1", addr_of(10'h105, 8'h40, 2'd0), 1'b1, 32'ha0000005);   // 2 0 1 3
        fill_row("fill_ev_w3", addr_of(10'h107, 8'h40, 2'd0), 32'ha0000007,
                 1, 10'h104, 32'ha0000004, 0);
        // back to back updates on set 0x10
        store_row("st_half_fwd", addr_of(10'h011, 8'h10, 2'd2), DC_SIZE_HALF, 32'h5a5a0000, 1);
        read_row("rd_half_fwd", addr_of(10'h011, 8'h10, 2'd0), 1'b1, 32'h5a5a0001);
        store_row("st_byte_fwd", addr_of(10'h011, 8'h10, 2'd0), DC_SIZE_BYTE, 32'h00000033, 1);
        read_row("rd_byte_fwd", addr_of(10'h011, 8'h10, 2'd0), 1'b1, 32'h5a5a0033);
        fill_row("fill_w1_idx10", addr_of(10'h012, 8'h10, 2'd0), 32'h600d0000, 0, 10'h0, 32'h0, 0);
        store_row("st_after_fill", addr_of(10'h012, 8'h10, 2'd0), DC_SIZE_WORD, 32'h600dbeef, 1);
        read_row("rd_after_store", addr_of(10'h012, 8'h10, 2'd0), 1'b1, 32'h600dbeef);
    endtask

// File: tb/dcache_tb.sv
// testbench for the data cache top; applies the vector table back to back and checks each response
module dcache_tb;
    import dcache_addr_pkg::*;
    import dcache_line_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int LATENCY      = 3;      // falling edges from drive to settled response

    typedef enum logic [1:0] {
        OP_READ,
        OP_STORE,
        OP_FILL
    } op_e;

    typedef struct {
        string    name;
        op_e      op;
        dc_addr_t addr;
        dc_size_e size;
        dc_word_t data;
        logic     hit;
        logic     miss;
        dc_word_t rdata;
        logic     ev_valid;
        dc_tag_t  ev_tag;
        dc_word_t ev_data;
        logic     ev_dirty;
    } row_t;

    logic     CLK;
    logic     arst_n;
    logic     read_en, write_en, fill;
    dc_addr_t addr;
    dc_size_e store_size;
    dc_word_t wdata;
    logic     resp_valid, hit, miss, evict_valid, evict_dirty;
    dc_word_t rdata, evict_data;
    dc_tag_t  evict_tag;

    row_t rows[$];            // filled by load_vectors
    bit   table_ready;
    int   errs;               // mismatches in the running test
    int   n_pass;
    int   n_fail;

    dcache_top dut (.*);

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // tag in 19:10, set in 9:2, byte lane in 1:0
    function automatic dc_addr_t addr_of(dc_tag_t tag, dc_index_t idx, dc_offset_t off);
        return {tag, idx, off};
    endfunction

    // reads ignore size and data, so those come from the random stream
    task automatic read_row(string name, dc_addr_t a, logic exp_hit, dc_word_t exp_rdata);
        rows.push_back('{name, OP_READ, a, dc_size_e'($urandom_range(3, 0)), $urandom,
                         exp_hit, !exp_hit, exp_rdata, 1'b0, 10'h0, 32'h0, 1'b0});
    endtask

    task automatic store_row(string name, dc_addr_t a, dc_size_e size, dc_word_t data,
                             logic exp_hit);
        rows.push_back('{name, OP_STORE, a, size, data,
                         exp_hit, !exp_hit, 32'h0, 1'b0, 10'h0, 32'h0, 1'b0});
    endtask

    // fill writes the whole word whatever the size
    task automatic fill_row(string name, dc_addr_t a, dc_word_t data, logic ev_valid,
                            dc_tag_t ev_tag, dc_word_t ev_data, logic ev_dirty);
        rows.push_back('{name, OP_FILL, a, dc_size_e'($urandom_range(3, 0)), data,
                         1'b0, 1'b0, 32'h0, ev_valid, ev_tag, ev_data, ev_dirty});
    endtask

    `include "dcache_tb_vectors.svh"

    task automatic check_field(string test, string field, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            $display("Fail %s: %s expected 0x%0h actual 0x%0h", test, field, exp, act);
            errs++;
        end
    endtask

    task automatic report_test(string name);
        if (errs == 0) begin
            n_pass++;
            $display("test %s ok", name);
        end else begin
            n_fail++;
            $display("test %s had %0d mismatches", name, errs);
        end
    endtask

    task automatic check_response(string name, logic exp_valid, row_t r);
        errs = 0;
        check_field(name, "resp_valid", exp_valid, resp_valid);
        check_field(name, "hit", r.hit, hit);
        check_field(name, "miss", r.miss, miss);
        check_field(name, "rdata", r.rdata, rdata);
        check_field(name, "evict_valid", r.ev_valid, evict_valid);
        check_field(name, "evict_tag", r.ev_tag, evict_tag);
        check_field(name, "evict_data", r.ev_data, evict_data);
        check_field(name, "evict_dirty", r.ev_dirty, evict_dirty);
        report_test(name);
    endtask

    task automatic drive_row(row_t r);
        read_en    = (r.op == OP_READ);
        write_en   = (r.op == OP_STORE);
        fill       = (r.op == OP_FILL);
        addr       = r.addr;
        store_size = r.size;
        wdata      = r.data;
    endtask

    initial begin
        row_t idle;
        void'($urandom(32'h8165));
        CLK        = 1'b0;
        arst_n     = 1'b0;
        read_en    = 1'b0;
        write_en   = 1'b0;
        fill       = 1'b0;
        addr       = '0;
        store_size = DC_SIZE_WORD;
        wdata      = '0;
        n_pass     = 0;
        n_fail     = 0;
        idle       = '{"idle", OP_READ, 20'h0, DC_SIZE_WORD, 32'h0,
                       1'b0, 1'b0, 32'h0, 1'b0, 10'h0, 32'h0, 1'b0};
        load_vectors();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        arst_n = 1'b1;
        check_response("reset_outputs", 1'b0, idle);   // all outputs cleared
        for (int k = 0; k < rows.size() + LATENCY + 1; k++) begin
            if (k >= rows.size() + LATENCY) begin
                check_response("drain_idle", 1'b0, idle);  // no request left, pulses back low
            end else if (k >= LATENCY) begin
                check_response(rows[k - LATENCY].name, 1'b1, rows[k - LATENCY]);
            end
            if (k < rows.size()) begin
                drive_row(rows[k]);
            end else begin
                read_en  = 1'b0;                          // drain the pipeline
                write_en = 1'b0;
                fill     = 1'b0;
            end
            @(negedge CLK);
        end
        $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // table length plus slack for reset and pipeline drain
    initial begin
        wait (table_ready);
        #((rows.size() + 20) * CLK_PERIOD);
        $display("Error: watchdog expired before the vector table finished");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+source
+incdir+tb
source/dcache_addr_pkg.sv
source/dcache_line_pkg.sv
source/dcache_way_ram.sv
source/dcache_tag_store.sv
source/dcache_lookup.sv
source/dcache_top.sv
tb/dcache_tb.sv
